// ==== rtl/blimp_pkg.sv ====
`default_nettype none
// ------------------------------
// Shared types and RV32 encodings for blimp
// Only the addi/add/mul/lw/sw subset is encoded here
// ------------------------------

package blimp_pkg;

  // ------------------------------
  // Basic widths
  // ------------------------------

  // Data or instruction word
  typedef logic [31:0] word_t;
  // Byte address, low two bits ignored by memory
  typedef logic [31:0] addr_t;
  // Architectural register number
  typedef logic [4:0]  reg_idx_t;

  // ------------------------------
  // Opcode field, inst[6:0]
  // ------------------------------

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  // Shared by base ALU ops and the M extension
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // funct3, inst[14:12]
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_MUL  = 3'b000;
  // Word-sized load/store
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7, inst[31:25], tells add from mul
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // ------------------------------
  // Retired instruction record
  // ------------------------------

  // waddr and wdata are zero whenever wen is low
  typedef struct packed {
    addr_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
  } trace_t;

endpackage

`default_nettype wire

// ==== rtl/mem_if.sv ====
`default_nettype none
// ------------------------------
// Word memory request/response bus
// No resp_ready, requesters always take responses
// ------------------------------

interface mem_if import blimp_pkg::*; ();

  // Request channel, valid/ready
  logic  req_valid;
  logic  req_ready;
  addr_t req_addr;
  logic  req_we;
  word_t req_wdata;

  // Response channel, data meaningless for stores
  logic  resp_valid;
  word_t resp_data;

  modport requester (
    output req_valid, req_addr, req_we, req_wdata,
    input  req_ready, resp_valid, resp_data
  );

  modport server (
    input  req_valid, req_addr, req_we, req_wdata,
    output req_ready, resp_valid, resp_data
  );

endinterface

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`default_nettype none
// ------------------------------
// Fetch unit, one buffered instruction
// Fetches and hands over only while run is high
// ------------------------------

module fetch_unit import blimp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,
  mem_if.requester mem,
  output logic     inst_valid,
  input  logic     inst_ready,
  output word_t    inst_word,
  output addr_t    inst_pc
);

  typedef enum logic [1:0] {f_idle, f_wait, f_full} fetch_state_t;

  fetch_state_t state;
  // pc of the word being fetched or buffered
  addr_t        pc;
  word_t        buf_word;

  // Request only with an empty buffer
  assign mem.req_valid = run && (state == f_idle);
  assign mem.req_addr  = pc;
  // Fetch never writes
  assign mem.req_we    = 1'b0;
  assign mem.req_wdata = '0;

  // Held back while stopped so nothing new retires
  assign inst_valid = run && (state == f_full);
  assign inst_word  = buf_word;
  assign inst_pc    = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= f_idle;
      pc    <= '0;
    end else begin
      case (state)
        f_idle: begin
          if (mem.req_valid && mem.req_ready) begin
            state <= f_wait;
          end
        end
        f_wait: begin
          // Response may still land after run drops
          if (mem.resp_valid) begin
            state <= f_full;
          end
        end
        f_full: begin
          // Next pc only once the core has the word
          if (inst_valid && inst_ready) begin
            state <= f_idle;
            pc    <= pc + 32'd4;
          end
        end
        default: state <= f_idle;
      endcase
    end
  end

  // Instruction buffer
  always_ff @(posedge clk) begin
    if ((state == f_wait) && mem.resp_valid) begin
      buf_word <= mem.resp_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/load_store_unit.sv ====
`default_nettype none
// ------------------------------
// Load/store unit, one command at a time
// Word accesses only, low address bits dropped
// ------------------------------

module load_store_unit import blimp_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ls_valid,
  output logic     ls_ready,
  input  logic     ls_we,
  input  addr_t    ls_addr,
  input  word_t    ls_wdata,
  output logic     ls_done,
  output word_t    ls_rdata,
  mem_if.requester mem
);

  typedef enum logic [1:0] {l_idle, l_req, l_wait} lsu_state_t;

  lsu_state_t state;
  // Captured command
  logic       cmd_we;
  addr_t      cmd_addr;
  word_t      cmd_wdata;

  // Busy from accept until the response
  assign ls_ready = (state == l_idle);

  assign mem.req_valid = (state == l_req);
  assign mem.req_addr  = {cmd_addr[31:2], 2'b00};
  assign mem.req_we    = cmd_we;
  assign mem.req_wdata = cmd_wdata;

  // One-cycle pulse, data only useful for loads
  assign ls_done  = (state == l_wait) && mem.resp_valid;
  assign ls_rdata = mem.resp_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= l_idle;
    end else begin
      case (state)
        l_idle: begin
          if (ls_valid) begin
            state <= l_req;
          end
        end
        l_req: begin
          // Hold the request until the arbiter grants
          if (mem.req_ready) begin
            state <= l_wait;
          end
        end
        l_wait: begin
          if (mem.resp_valid) begin
            state <= l_idle;
          end
        end
        default: state <= l_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ls_valid && ls_ready) begin
      cmd_we    <= ls_we;
      cmd_addr  <= ls_addr;
      cmd_wdata <= ls_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`default_nettype none
// ------------------------------
// Fixed-priority arbiter, data before fetch
// One transaction in flight, MEM_WORDS a power of two
// ------------------------------

module mem_arbiter import blimp_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n,
  mem_if.server    inst_side,
  mem_if.server    data_side,
  mem_if.requester mem_side
);

  // Byte-address mask, word index wraps at MEM_WORDS
  localparam addr_t ADDR_MASK = addr_t'(MEM_WORDS * 4 - 1);

  logic outstanding;
  // High when the pending response belongs to data
  logic owner_data;
  logic pick_data;
  logic issue;

  // ------------------------------
  // Request path
  // ------------------------------

  // Data wins any tie
  assign pick_data = data_side.req_valid;

  assign mem_side.req_valid = !outstanding && (data_side.req_valid || inst_side.req_valid);
  assign mem_side.req_addr  = (pick_data ? data_side.req_addr : inst_side.req_addr) & ADDR_MASK;
  assign mem_side.req_we    = pick_data ? data_side.req_we : inst_side.req_we;
  assign mem_side.req_wdata = pick_data ? data_side.req_wdata : inst_side.req_wdata;

  // Both peers stalled while a transaction is open
  assign data_side.req_ready = !outstanding && mem_side.req_ready;
  assign inst_side.req_ready = !outstanding && mem_side.req_ready && !data_side.req_valid;

  assign issue = mem_side.req_valid && mem_side.req_ready;

  // ------------------------------
  // Response path
  // ------------------------------

  // Steered by owner, data bus shared
  assign data_side.resp_valid = mem_side.resp_valid && outstanding && owner_data;
  assign inst_side.resp_valid = mem_side.resp_valid && outstanding && !owner_data;
  assign data_side.resp_data  = mem_side.resp_data;
  assign inst_side.resp_data  = mem_side.resp_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
      owner_data  <= 1'b0;
    end else begin
      if (issue) begin
        outstanding <= 1'b1;
        owner_data  <= pick_data;
      end else if (mem_side.resp_valid) begin
        // Closes the transaction, new grant next cycle
        outstanding <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/unified_mem.sv ====
`default_nettype none
// ------------------------------
// Single-port word memory, read latency one cycle
// Load port wins over a same-cycle bus write
// Needs two reset cycles before resp_valid is clean
// ------------------------------

module unified_mem import blimp_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  mem_if.server port,
  input  logic  load_valid,
  input  addr_t load_addr,
  input  word_t load_data
);

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  word_t               mem [MEM_WORDS];
  logic [IDX_BITS-1:0] req_idx;
  logic [IDX_BITS-1:0] load_idx;
  logic                accept;

  // Word index from byte address
  assign req_idx  = port.req_addr[IDX_BITS+1:2];
  assign load_idx = load_addr[IDX_BITS+1:2];

  // Never back-pressures
  assign port.req_ready = 1'b1;
  assign accept = port.req_valid && port.req_ready;

  // Response exactly one cycle after accept
  always_ff @(posedge clk) begin
    port.resp_valid <= accept;
  end

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (load_valid) begin
      mem[load_idx] <= load_data;
    end else if (accept && port.req_we) begin
      mem[req_idx] <= port.req_wdata;
    end
  end

  // Read before write, stores return the old word
  always_ff @(posedge clk) begin
    if (accept) begin
      port.resp_data <= mem[req_idx];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/blimp_core.sv ====
`default_nettype none
// ------------------------------
// Multi-cycle core, one instruction in flight
// addi/add/mul/lw/sw only, anything else retires as a no-op
// ------------------------------

module blimp_core import blimp_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   inst_valid,
  output logic   inst_ready,
  input  word_t  inst_word,
  input  addr_t  inst_pc,
  output logic   ls_valid,
  input  logic   ls_ready,
  output logic   ls_we,
  output addr_t  ls_addr,
  output word_t  ls_wdata,
  input  logic   ls_done,
  input  word_t  ls_rdata,
  output logic   trace_valid,
  output trace_t trace
);

  typedef enum logic [1:0] {c_ready, c_mem, c_retire} core_state_t;

  core_state_t state;
  word_t       regs [32];

  // Decode fields
  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      rs1_val;
  word_t      rs2_val;
  logic       is_addi;
  logic       is_add;
  logic       is_mul;
  logic       is_lw;
  logic       is_sw;
  word_t      alu_result;
  logic       accept;

  // Instruction held until retire
  addr_t    cur_pc;
  reg_idx_t cur_rd;
  logic     cur_wen;
  logic     cur_load;
  word_t    cur_result;
  logic     ls_pending;
  logic     retire;
  word_t    retire_data;

  // ------------------------------
  // Decode
  // ------------------------------

  assign opcode = inst_word[6:0];
  assign rd     = inst_word[11:7];
  assign funct3 = inst_word[14:12];
  assign rs1    = inst_word[19:15];
  assign rs2    = inst_word[24:20];
  assign funct7 = inst_word[31:25];

  // I and S immediates, sign-extended
  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};

  assign is_addi = (opcode == OPC_OP_IMM) && (funct3 == F3_ADD);
  assign is_add  = (opcode == OPC_OP) && (funct3 == F3_ADD) && (funct7 == F7_BASE);
  assign is_mul  = (opcode == OPC_OP) && (funct3 == F3_MUL) && (funct7 == F7_MULDIV);
  assign is_lw   = (opcode == OPC_LOAD) && (funct3 == F3_WORD);
  assign is_sw   = (opcode == OPC_STORE) && (funct3 == F3_WORD);

  // x0 hardwired to zero
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  // Low 32 bits only for mul
  always_comb begin
    alu_result = '0;
    if (is_addi) begin
      alu_result = rs1_val + imm_i;
    end else if (is_add) begin
      alu_result = rs1_val + rs2_val;
    end else if (is_mul) begin
      alu_result = rs1_val * rs2_val;
    end
  end

  assign inst_ready = (state == c_ready);
  assign accept     = inst_valid && inst_ready;
  assign ls_valid   = ls_pending;

  // ------------------------------
  // Control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= c_ready;
      ls_pending <= 1'b0;
    end else begin
      case (state)
        c_ready: begin
          if (accept && (is_lw || is_sw)) begin
            state      <= c_mem;
            ls_pending <= 1'b1;
          end else if (accept) begin
            state <= c_retire;
          end
        end
        c_mem: begin
          if (ls_valid && ls_ready) begin
            ls_pending <= 1'b0;
          end
          // Memory op retires with ls_done
          if (ls_done) begin
            state <= c_ready;
          end
        end
        default: state <= c_ready;
      endcase
    end
  end

  // Capture at accept, regfile write at retire
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_pc     <= inst_pc;
      cur_rd     <= rd;
      cur_load   <= is_lw;
      cur_wen    <= (is_addi || is_add || is_mul || is_lw) && (rd != '0);
      cur_result <= alu_result;
      ls_we      <= is_sw;
      ls_addr    <= rs1_val + (is_sw ? imm_s : imm_i);
      ls_wdata   <= rs2_val;
    end
    if (retire && cur_wen) begin
      regs[cur_rd] <= retire_data;
    end
  end

  // ------------------------------
  // Retire and trace
  // ------------------------------

  assign retire      = (state == c_retire) || ((state == c_mem) && ls_done);
  assign retire_data = cur_load ? ls_rdata : cur_result;

  assign trace_valid = retire;
  assign trace.pc    = cur_pc;
  assign trace.wen   = cur_wen;
  assign trace.waddr = cur_wen ? cur_rd : '0;
  assign trace.wdata = cur_wen ? retire_data : '0;

endmodule

`default_nettype wire

// ==== rtl/blimp_top.sv ====
`default_nettype none
// ------------------------------
// blimp top level, plain ports only
// Load port meant for use while run is low
// ------------------------------

module blimp_top import blimp_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,
  input  logic     load_valid,
  input  addr_t    load_addr,
  input  word_t    load_data,
  output logic     trace_valid,
  output addr_t    trace_pc,
  output reg_idx_t trace_waddr,
  output word_t    trace_wdata,
  output logic     trace_wen
);

  // Fetch, data and memory-side buses
  mem_if inst_bus ();
  mem_if data_bus ();
  mem_if mem_bus ();

  // Fetch to core
  logic   inst_valid;
  logic   inst_ready;
  word_t  inst_word;
  addr_t  inst_pc;

  // Core to load/store unit
  logic   ls_valid;
  logic   ls_ready;
  logic   ls_we;
  addr_t  ls_addr;
  word_t  ls_wdata;
  logic   ls_done;
  word_t  ls_rdata;

  trace_t core_trace;

  fetch_unit u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .mem        (inst_bus.requester),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst_word  (inst_word),
    .inst_pc    (inst_pc)
  );

  blimp_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst_word   (inst_word),
    .inst_pc     (inst_pc),
    .ls_valid    (ls_valid),
    .ls_ready    (ls_ready),
    .ls_we       (ls_we),
    .ls_addr     (ls_addr),
    .ls_wdata    (ls_wdata),
    .ls_done     (ls_done),
    .ls_rdata    (ls_rdata),
    .trace_valid (trace_valid),
    .trace       (core_trace)
  );

  load_store_unit u_lsu (
    .clk      (clk),
    .rst_n    (rst_n),
    .ls_valid (ls_valid),
    .ls_ready (ls_ready),
    .ls_we    (ls_we),
    .ls_addr  (ls_addr),
    .ls_wdata (ls_wdata),
    .ls_done  (ls_done),
    .ls_rdata (ls_rdata),
    .mem      (data_bus.requester)
  );

  mem_arbiter #(.MEM_WORDS(MEM_WORDS)) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_side (inst_bus.server),
    .data_side (data_bus.server),
    .mem_side  (mem_bus.requester)
  );

  unified_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
    .clk        (clk),
    .port       (mem_bus.server),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  // Trace record out as plain ports
  assign trace_pc    = core_trace.pc;
  assign trace_waddr = core_trace.waddr;
  assign trace_wdata = core_trace.wdata;
  assign trace_wen   = core_trace.wen;

endmodule

`default_nettype wire

// ==== sim/blimp_tb.sv ====
`default_nettype none
// ------------------------------
// Testbench for blimp_top, runs programs from pc 0 after each reset
// Registers persist across resets, so the first program writes x1..x31
// Data region is words 128..255, programs live below it
// ------------------------------

module blimp_tb import blimp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD    = 8;
  localparam int DRIVE_DLY     = 1;
  localparam int MEM_WORDS     = 256;
  localparam int DATA_BASE     = 128;
  localparam int SETTLE_CYCLES = 10;
  localparam logic [15:0] LFSR_SEED = 16'd90;

  // Program sizes, used for the watchdog budget
  localparam int INIT_LEN    = 31;
  localparam int ADDI_LEN    = 7;
  localparam int ALU_LEN     = 9;
  localparam int MEM_LEN     = 7;
  localparam int RAND_LEN    = 50;
  localparam int RAND_PROGS  = 3;
  localparam int TOTAL_INSTR = INIT_LEN + ADDI_LEN + ALU_LEN + MEM_LEN + RAND_PROGS * RAND_LEN;
  // Loads, resets and settling fit in the margin
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_INSTR + 1500;

  // Instruction kinds of the subset
  localparam logic [2:0] OP_ADDI = 3'd0;
  localparam logic [2:0] OP_ADD  = 3'd1;
  localparam logic [2:0] OP_MUL  = 3'd2;
  localparam logic [2:0] OP_LW   = 3'd3;
  localparam logic [2:0] OP_SW   = 3'd4;

  typedef struct packed {
    logic [2:0]  op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
  } instr_t;

  logic     clk;
  logic     rst_n;
  logic     run;
  logic     load_valid;
  addr_t    load_addr;
  word_t    load_data;
  logic     trace_valid;
  addr_t    trace_pc;
  reg_idx_t trace_waddr;
  word_t    trace_wdata;
  logic     trace_wen;

  // Reference state and expected trace
  word_t       model_regs [32];
  word_t       model_mem [MEM_WORDS];
  instr_t      prog_q [$];
  trace_t      exp_q [$];
  logic [15:0] lfsr_state;
  string       cur_test;
  int          events_seen;
  int          n_checks;
  int          n_errors;
  int          idle_events;

  blimp_top #(.MEM_WORDS(MEM_WORDS)) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .load_valid  (load_valid),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .trace_valid (trace_valid),
    .trace_pc    (trace_pc),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata),
    .trace_wen   (trace_wen)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------
  // Encoders and LFSR
  // ------------------------------

  function automatic word_t enc_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, F3_ADD, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t enc_add(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {F7_BASE, rs2, rs1, F3_ADD, rd, OPC_OP};
  endfunction

  function automatic word_t enc_mul(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {F7_MULDIV, rs2, rs1, F3_MUL, rd, OPC_OP};
  endfunction

  function automatic word_t enc_lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, F3_WORD, rd, OPC_LOAD};
  endfunction

  // S format splits the immediate around rs1/rs2
  function automatic word_t enc_sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t encode(instr_t ins);
    case (ins.op)
      OP_ADDI: return enc_addi(ins.rd, ins.rs1, ins.imm);
      OP_ADD:  return enc_add(ins.rd, ins.rs1, ins.rs2);
      OP_MUL:  return enc_mul(ins.rd, ins.rs1, ins.rs2);
      OP_LW:   return enc_lw(ins.rd, ins.rs1, ins.imm);
      default: return enc_sw(ins.rs2, ins.rs1, ins.imm);
    endcase
  endfunction

  function automatic instr_t make_instr(logic [2:0] op, int rd, int rs1, int rs2, int imm);
    instr_t ins;
    ins.op  = op;
    ins.rd  = 5'(rd);
    ins.rs1 = 5'(rs1);
    ins.rs2 = 5'(rs2);
    ins.imm = 12'(imm);
    return ins;
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic word_t rand_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // ------------------------------
  // Reference ISA model
  // ------------------------------

  // Executes one instruction, returns its trace record
  function automatic trace_t ref_step(instr_t ins, addr_t pc);
    trace_t t;
    word_t  a;
    word_t  b;
    word_t  imm_x;
    word_t  val;
    int     idx;
    logic   writes;
    a      = model_regs[ins.rs1];
    b      = model_regs[ins.rs2];
    imm_x  = {{20{ins.imm[11]}}, ins.imm};
    // Word index wraps at the memory depth
    idx    = int'(((a + imm_x) >> 2) % word_t'(MEM_WORDS));
    writes = 1'b1;
    val    = '0;
    case (ins.op)
      OP_ADDI: val = a + imm_x;
      OP_ADD:  val = a + b;
      OP_MUL:  val = a * b;
      OP_LW:   val = model_mem[idx];
      default: begin
        writes         = 1'b0;
        model_mem[idx] = b;
      end
    endcase
    if (writes && ins.rd != 5'd0) begin
      model_regs[ins.rd] = val;
    end
    t.pc    = pc;
    t.wen   = writes && (ins.rd != 5'd0);
    t.waddr = t.wen ? ins.rd : 5'd0;
    t.wdata = t.wen ? val : '0;
    return t;
  endfunction

  task automatic check_value(string what, word_t expected, word_t actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("MISMATCH %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  // Compare each retired instruction with the oldest expected one
  always @(negedge clk) begin : compare_trace
    trace_t e;
    if (rst_n && trace_valid) begin
      // Every retirement counts, expected or not
      events_seen++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("ERROR: %s: trace event at pc %h while none was expected",
                 cur_test, trace_pc);
      end else begin
        e = exp_q.pop_front();
        check_value({cur_test, " pc"}, e.pc, trace_pc);
        check_value({cur_test, " wen"}, {31'b0, e.wen}, {31'b0, trace_wen});
        check_value({cur_test, " waddr"}, {27'b0, e.waddr}, {27'b0, trace_waddr});
        check_value({cur_test, " wdata"}, e.wdata, trace_wdata);
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  endtask

  task automatic load_word(addr_t addr, word_t data);
    load_valid = 1'b1;
    load_addr  = addr;
    load_data  = data;
    @(posedge clk);
    #DRIVE_DLY;
    load_valid = 1'b0;
  endtask

  // Fill pattern mixes every address bit
  task automatic preload_data();
    word_t d;
    for (int w = DATA_BASE; w < MEM_WORDS; w++) begin
      d = (word_t'(w) * 32'h9E37_79B9) ^ 32'hC3A5_0000 ^ word_t'(w);
      load_word(addr_t'(4 * w), d);
      model_mem[w] = d;
    end
  endtask

  // Load prog_q at pc 0, run it to completion, then stop
  task automatic run_program(string name);
    int len;
    len = prog_q.size();
    apply_reset();
    for (int i = 0; i < len; i++) begin
      load_word(addr_t'(4 * i), encode(prog_q[i]));
    end
    for (int i = 0; i < len; i++) begin
      exp_q.push_back(ref_step(prog_q[i], addr_t'(4 * i)));
    end
    cur_test    = name;
    events_seen = 0;
    run         = 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    run = 1'b0;
    // Let the in-flight fetch drain
    repeat (SETTLE_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    check_value({name, " event count"}, word_t'(len), word_t'(events_seen));
  endtask

  // lw/sw use x0 as base so addresses stay in the data region
  task automatic build_random_program();
    logic [2:0] op;
    int         rd;
    int         rs1;
    int         rs2;
    int         imm;
    prog_q.delete();
    repeat (RAND_LEN) begin
      op  = 3'(rand_bits(3) % 5);
      rd  = int'(rand_bits(5));
      rs1 = int'(rand_bits(5));
      rs2 = int'(rand_bits(5));
      imm = int'(rand_bits(12));
      if (op == OP_LW || op == OP_SW) begin
        rs1 = 0;
        imm = 4 * DATA_BASE + 4 * int'(rand_bits(7));
      end
      prog_q.push_back(make_instr(op, rd, rs1, rs2, imm));
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    rst_n       = 1'b0;
    run         = 1'b0;
    load_valid  = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    lfsr_state  = LFSR_SEED;
    cur_test    = "reset_idle";
    events_seen = 0;
    n_checks    = 0;
    n_errors    = 0;
    idle_events = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int w = 0; w < MEM_WORDS; w++) begin
      model_mem[w] = '0;
    end

    // No retirement while run is low
    apply_reset();
    preload_data();
    repeat (20) begin
      @(negedge clk);
      if (trace_valid) begin
        idle_events++;
      end
    end
    check_value("reset_idle trace events", '0, word_t'(idle_events));
    @(posedge clk);
    #DRIVE_DLY;

    // Defined values in x1..x31, first event at pc 0
    prog_q.delete();
    for (int r = 1; r < 32; r++) begin
      prog_q.push_back(make_instr(OP_ADDI, r, 0, 0, ((r * 397) % 4096) - 2048));
    end
    run_program("init_regs");

    // addi chain, x0 write and read back
    prog_q.delete();
    prog_q.push_back(make_instr(OP_ADDI, 1, 0, 0, 100));
    prog_q.push_back(make_instr(OP_ADDI, 2, 1, 0, -37));
    prog_q.push_back(make_instr(OP_ADDI, 0, 1, 0, 55));
    prog_q.push_back(make_instr(OP_ADDI, 3, 0, 0, -1));
    prog_q.push_back(make_instr(OP_ADDI, 4, 3, 0, -2048));
    prog_q.push_back(make_instr(OP_ADDI, 5, 4, 0, 2047));
    prog_q.push_back(make_instr(OP_ADDI, 6, 2, 0, 0));
    run_program("addi_chain");

    // Dependent add/mul with 32-bit overflow
    prog_q.delete();
    prog_q.push_back(make_instr(OP_ADDI, 8, 0, 0, 1234));
    prog_q.push_back(make_instr(OP_MUL, 9, 8, 8, 0));
    prog_q.push_back(make_instr(OP_MUL, 10, 9, 9, 0));
    prog_q.push_back(make_instr(OP_ADD, 11, 10, 9, 0));
    prog_q.push_back(make_instr(OP_ADDI, 12, 0, 0, -3));
    prog_q.push_back(make_instr(OP_MUL, 13, 12, 10, 0));
    prog_q.push_back(make_instr(OP_ADD, 14, 13, 14, 0));
    prog_q.push_back(make_instr(OP_MUL, 0, 13, 13, 0));
    prog_q.push_back(make_instr(OP_ADD, 15, 0, 13, 0));
    run_program("add_mul");

    // Store/load pair, preloaded word, wrapped addresses
    prog_q.delete();
    prog_q.push_back(make_instr(OP_ADDI, 16, 0, 0, 1445));
    prog_q.push_back(make_instr(OP_SW, 0, 0, 16, 600));
    prog_q.push_back(make_instr(OP_LW, 17, 0, 0, 600));
    prog_q.push_back(make_instr(OP_LW, 18, 0, 0, 520));
    prog_q.push_back(make_instr(OP_LW, 19, 0, 0, 1544));
    prog_q.push_back(make_instr(OP_SW, 0, 0, 18, 1604));
    prog_q.push_back(make_instr(OP_LW, 20, 0, 0, 580));
    run_program("load_store");

    for (int p = 0; p < RAND_PROGS; p++) begin
      build_random_program();
      run_program($sformatf("random_%0d", p));
    end

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget of 40 cycles per instruction plus margin
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles in %s, instructions stopped retiring",
             TIMEOUT_CYCLES, cur_test);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/blimp_pkg.sv
rtl/mem_if.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/unified_mem.sv
rtl/blimp_core.sv
rtl/blimp_top.sv
sim/blimp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module blimp_tb -f flist.f -o blimp_sim \
  && ./obj_dir/blimp_sim | tee /dev/stderr | grep -x "All checks passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
